//--- rtl/gpmc_bus_pkg.sv
//////////////////////////////////////////////////
// Host bus constants
// Address and data widths, window sizes, item
// buffer depth and the have_space threshold
//////////////////////////////////////////////////
`default_nettype none

package gpmc_bus_pkg;

   // Word address em_a_i[10:1] and data bus width
   localparam int EM_ADDR_W = 10;
   localparam int EM_DATA_W = 16;

   // CS4 data window uses the whole address
   localparam int DATA_ADDR_W = 10;
   // CS6 control window, em_a_i[5:1]
   localparam int CTRL_ADDR_W = 5;

   // Item buffers on the bus side, 16 entries
   localparam int BUS_BUF_LOG2 = 4;

   // Free entries needed to raise have_space
   localparam int HAVE_SPACE_MIN = 8;

endpackage

`default_nettype wire

//--- rtl/fifo_pkg.sv
//////////////////////////////////////////////////
// Stream format constants
// 18-bit item layout, 36-bit frame word, occupancy
// codes, buffer depths and the frame word union
//////////////////////////////////////////////////
`default_nettype none

package fifo_pkg;

   // Item is {eof, sof, data[15:0]}
   localparam int ITEM_W       = 18;
   localparam int ITEM_SOF_BIT = 16;
   localparam int ITEM_EOF_BIT = 17;

   // Frame word is {occ, eof, sof, data[31:0]}
   localparam int WORD_W = 36;

   // Occupancy of the last word
   localparam logic [1:0] OCC_FULL     = 2'd0;
   localparam logic [1:0] OCC_LOW_ONLY = 2'd1;

   // Depths of the 36-bit buffers, as log2
   localparam int TX_FIFO_LOG2   = 5;
   localparam int RX_FIFO_LOG2   = 5;
   localparam int CTRL_FIFO_LOG2 = 3;

   //////////////////////////////////////////////////
   // Frame word, seen whole or as two halves
   //////////////////////////////////////////////////
   typedef struct packed {
      logic [1:0]  occ;
      logic        eof;
      logic        sof;
      logic [31:0] data;
   } fifo36_frame_t;

   // Little endian, first item in lo
   typedef struct packed {
      logic [1:0]  occ;
      logic        eof;
      logic        sof;
      logic [15:0] hi;
      logic [15:0] lo;
   } fifo36_halves_t;

   typedef union packed {
      fifo36_frame_t  frame;
      fifo36_halves_t halves;
   } fifo36_word_u;

endpackage

`default_nettype wire

//--- rtl/fifo_buffer.sv
//////////////////////////////////////////////////
// Synchronous FIFO for 36-bit frame words
// RAM array behind a registered output stage
//////////////////////////////////////////////////
`default_nettype none

module fifo_buffer #(
   parameter int SIZE_LOG2 = 5
) (
   input  logic                        fifo_clk_i,
   input  logic                        rst_n_i,
   input  logic [fifo_pkg::WORD_W-1:0] data_i,
   input  logic                        src_rdy_i,
   output logic                        dst_rdy_o,
   output logic [fifo_pkg::WORD_W-1:0] data_o,
   output logic                        src_rdy_o,
   input  logic                        dst_rdy_i
);
   import fifo_pkg::*;

   logic [WORD_W-1:0]    mem [2**SIZE_LOG2];
   logic [SIZE_LOG2-1:0] wr_ptr;
   logic [SIZE_LOG2-1:0] rd_ptr;
   // Words held in the RAM without the output stage
   logic [SIZE_LOG2:0]   count;
   logic                 push;
   logic                 out_load;
   logic                 ram_empty;
   logic                 pop;
   logic                 bypass;
   logic                 ram_wr;

   assign dst_rdy_o = !count[SIZE_LOG2];
   assign push      = src_rdy_i && dst_rdy_o;
   assign ram_empty = (count == '0);
   // Output stage free or emptying this cycle
   assign out_load  = !src_rdy_o || dst_rdy_i;
   assign pop       = out_load && !ram_empty;
   // New word goes straight to the output past an empty RAM
   assign bypass    = out_load && ram_empty && push;
   assign ram_wr    = push && !bypass;

   always_ff @(posedge fifo_clk_i) begin
      if (ram_wr) mem[wr_ptr] <= data_i;
      if (pop) data_o <= mem[rd_ptr];
      else if (bypass) data_o <= data_i;
   end

   always_ff @(posedge fifo_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         src_rdy_o <= 1'b0;
      end else begin
         if (ram_wr) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + ram_wr - pop;
         if (out_load) src_rdy_o <= pop || bypass;
      end
   end

   a_count_in_range : assert property (@(posedge fifo_clk_i) disable iff (!rst_n_i)
      count <= (2**SIZE_LOG2));

endmodule

`default_nettype wire

//--- rtl/gpmc_to_fifo.sv
//////////////////////////////////////////////////
// Host write side of one window
// Write strobes fill a 16-item ring buffer that
// drains as an 18-bit stream
//////////////////////////////////////////////////
`default_nettype none

module gpmc_to_fifo #(
   parameter int ADDR_WIDTH = 10
) (
   input  logic                               fifo_clk_i,
   input  logic                               rst_n_i,
   input  logic                               we_i,
   input  logic [ADDR_WIDTH-1:0]              addr_i,
   input  logic [gpmc_bus_pkg::EM_DATA_W-1:0] data_i,
   output logic [fifo_pkg::ITEM_W-1:0]        item_o,
   output logic                               src_rdy_o,
   input  logic                               dst_rdy_i,
   output logic                               have_space_o
);
   import gpmc_bus_pkg::*;
   import fifo_pkg::*;

   // Item storage
   logic [ITEM_W-1:0]     mem [(1 << BUS_BUF_LOG2)];
   logic [BUS_BUF_LOG2-1:0] wr_ptr;
   logic [BUS_BUF_LOG2-1:0] rd_ptr;
   // One extra bit so full is the top bit
   logic [BUS_BUF_LOG2:0] count;
   logic                  full;
   logic                  push;
   logic                  pop;
   logic [ITEM_W-1:0]     wr_item;

   assign full = count[BUS_BUF_LOG2];
   assign push = we_i && !full;
   assign pop  = src_rdy_o && dst_rdy_i;

   // Zero address opens a frame and the top address bit closes it
   always_comb begin
      wr_item               = '0;
      wr_item[15:0]         = data_i;
      wr_item[ITEM_SOF_BIT] = (addr_i == '0);
      wr_item[ITEM_EOF_BIT] = addr_i[ADDR_WIDTH-1];
   end

   always_ff @(posedge fifo_clk_i) begin
      if (push) begin
         mem[wr_ptr] <= wr_item;
      end
   end

   always_ff @(posedge fifo_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         count <= count + push - pop;
      end
   end

   // Head of the ring is the stream output
   assign item_o       = mem[rd_ptr];
   assign src_rdy_o    = (count != '0);
   assign have_space_o = ((1 << BUS_BUF_LOG2) - count) >= HAVE_SPACE_MIN;

   // Host keeps to its have_space budget so nothing is dropped
   a_no_write_full : assert property (@(posedge fifo_clk_i) disable iff (!rst_n_i)
      we_i |-> !full);

endmodule

`default_nettype wire

//--- rtl/fifo_to_gpmc.sv
//////////////////////////////////////////////////
// Host read side of one window
// 16-item ring buffer, complete-frame counter and
// registered read data
//////////////////////////////////////////////////
`default_nettype none

module fifo_to_gpmc (
   input  logic                               fifo_clk_i,
   input  logic                               rst_n_i,
   input  logic [fifo_pkg::ITEM_W-1:0]        item_i,
   input  logic                               src_rdy_i,
   output logic                               dst_rdy_o,
   input  logic                               rd_i,
   output logic [gpmc_bus_pkg::EM_DATA_W-1:0] data_o,
   output logic                               data_oe_o,
   output logic                               data_available_o
);
   import gpmc_bus_pkg::*;
   import fifo_pkg::*;

   logic [ITEM_W-1:0]       mem [(1 << BUS_BUF_LOG2)];
   logic [BUS_BUF_LOG2-1:0] wr_ptr;
   logic [BUS_BUF_LOG2-1:0] rd_ptr;
   logic [BUS_BUF_LOG2:0]   count;
   // Number of eof items held
   logic [BUS_BUF_LOG2:0]   frames;
   logic                    full;
   logic                    empty;
   logic                    push;
   logic                    pop;
   logic [ITEM_W-1:0]       head;
   logic                    push_eof;
   logic                    pop_eof;

   assign full  = count[BUS_BUF_LOG2];
   assign empty = (count == '0);
   assign head  = mem[rd_ptr];

   // Take items whenever there is room
   assign dst_rdy_o = !full;
   assign push      = src_rdy_i && !full;
   // Read of an empty buffer pops nothing
   assign pop       = rd_i && !empty;

   assign push_eof = push && item_i[ITEM_EOF_BIT];
   assign pop_eof  = pop && head[ITEM_EOF_BIT];

   always_ff @(posedge fifo_clk_i) begin
      if (push) begin
         mem[wr_ptr] <= item_i;
      end
   end

   always_ff @(posedge fifo_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         frames <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         count  <= count + push - pop;
         frames <= frames + push_eof - pop_eof;
      end
   end

   //////////////////////////////////////////////////
   // Bus read data, one cycle after the access
   //////////////////////////////////////////////////
   always_ff @(posedge fifo_clk_i) begin
      if (rd_i) begin
         // Zero when nothing is buffered
         data_o <= empty ? '0 : head[EM_DATA_W-1:0];
      end
   end

   always_ff @(posedge fifo_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         data_oe_o <= 1'b0;
      end else begin
         data_oe_o <= rd_i;
      end
   end

   // Whole frame waiting, or full with a frame too long to fit
   assign data_available_o = (frames != '0) || full;

   // An eof leaving was counted when it came in
   a_frames_no_underflow : assert property (@(posedge fifo_clk_i) disable iff (!rst_n_i)
      pop_eof |-> (frames != '0));

endmodule

`default_nettype wire

//--- rtl/fifo19_to_fifo36.sv
//////////////////////////////////////////////////
// Item to frame word packer
// Pairs of 18-bit items become one 36-bit word,
// first item in the low half
//////////////////////////////////////////////////
`default_nettype none

module fifo19_to_fifo36 (
   input  logic                        fifo_clk_i,
   input  logic                        rst_n_i,
   input  logic [fifo_pkg::ITEM_W-1:0] f19_data_i,
   input  logic                        f19_src_rdy_i,
   output logic                        f19_dst_rdy_o,
   output fifo_pkg::fifo36_word_u      f36_data_o,
   output logic                        f36_src_rdy_o,
   input  logic                        f36_dst_rdy_i
);
   import fifo_pkg::*;

   // Low half stored and waiting for the high one
   logic have_lo;
   logic accept;
   logic item_eof;
   logic closes;

   // The word register is also the build area
   assign f19_dst_rdy_o = !f36_src_rdy_o || f36_dst_rdy_i;
   assign accept        = f19_src_rdy_i && f19_dst_rdy_o;
   assign item_eof      = f19_data_i[ITEM_EOF_BIT];
   // Second half or eof on a low half closes the word
   assign closes        = have_lo || item_eof;

   always_ff @(posedge fifo_clk_i) begin
      if (accept && !have_lo) begin
         f36_data_o.halves.lo  <= f19_data_i[15:0];
         f36_data_o.halves.sof <= f19_data_i[ITEM_SOF_BIT];
         // Early close leaves the high half empty
         f36_data_o.halves.hi  <= '0;
         f36_data_o.halves.eof <= item_eof;
         f36_data_o.halves.occ <= item_eof ? OCC_LOW_ONLY : OCC_FULL;
      end else if (accept) begin
         f36_data_o.halves.hi  <= f19_data_i[15:0];
         f36_data_o.halves.eof <= item_eof;
         f36_data_o.halves.occ <= OCC_FULL;
      end
   end

   always_ff @(posedge fifo_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         have_lo       <= 1'b0;
         f36_src_rdy_o <= 1'b0;
      end else begin
         if (f36_src_rdy_o && f36_dst_rdy_i) f36_src_rdy_o <= 1'b0;
         if (accept && closes) f36_src_rdy_o <= 1'b1;
         if (accept) have_lo <= !closes;
      end
   end

   a_hold_stable : assert property (@(posedge fifo_clk_i) disable iff (!rst_n_i)
      f36_src_rdy_o && !f36_dst_rdy_i |=> f36_src_rdy_o && $stable(f36_data_o));

endmodule

`default_nettype wire

//--- rtl/fifo36_to_fifo19.sv
//////////////////////////////////////////////////
// Frame word to item splitter
// Low half first, high half skipped on a word
// marked OCC_LOW_ONLY
//////////////////////////////////////////////////
`default_nettype none

module fifo36_to_fifo19 (
   input  logic                        fifo_clk_i,
   input  logic                        rst_n_i,
   input  fifo_pkg::fifo36_word_u      f36_data_i,
   input  logic                        f36_src_rdy_i,
   output logic                        f36_dst_rdy_o,
   output logic [fifo_pkg::ITEM_W-1:0] f19_data_o,
   output logic                        f19_src_rdy_o,
   input  logic                        f19_dst_rdy_i
);
   import fifo_pkg::*;

   fifo36_word_u word_q;
   // Set while the high half is on the output
   logic         phase_hi;
   logic         low_only;
   logic         last;
   logic         leave;
   logic         load;

   assign low_only = (word_q.halves.occ == OCC_LOW_ONLY);
   // Item leaving now is the last of its word
   assign last     = phase_hi || low_only;
   assign leave    = f19_src_rdy_o && f19_dst_rdy_i;

   assign f36_dst_rdy_o = !f19_src_rdy_o || (f19_dst_rdy_i && last);
   assign load          = f36_src_rdy_i && f36_dst_rdy_o;

   // sof only on lo, eof on hi or on a lone lo
   always_comb begin
      f19_data_o[15:0]         = phase_hi ? word_q.halves.hi : word_q.halves.lo;
      f19_data_o[ITEM_SOF_BIT] = !phase_hi && word_q.halves.sof;
      f19_data_o[ITEM_EOF_BIT] = word_q.halves.eof && last;
   end

   always_ff @(posedge fifo_clk_i) begin
      if (load) word_q <= f36_data_i;
   end

   always_ff @(posedge fifo_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         f19_src_rdy_o <= 1'b0;
         phase_hi      <= 1'b0;
      end else begin
         if (leave) phase_hi <= !last;
         if (leave && last) f19_src_rdy_o <= 1'b0;
         if (load) f19_src_rdy_o <= 1'b1;
      end
   end

   a_hold_stable : assert property (@(posedge fifo_clk_i) disable iff (!rst_n_i)
      f19_src_rdy_o && !f19_dst_rdy_i |=> f19_src_rdy_o && $stable(f19_data_o));

endmodule

`default_nettype wire

//--- rtl/gpmc.sv
//////////////////////////////////////////////////
// GPMC to FIFO bridge, top level
// CS4 data window and CS6 control window, each
// with a write and a read path
//////////////////////////////////////////////////
`default_nettype none

module gpmc (
   input  logic                               fifo_clk_i,
   input  logic                               rst_n_i,
   input  logic [gpmc_bus_pkg::EM_ADDR_W:1]   em_a_i,
   input  logic [gpmc_bus_pkg::EM_DATA_W-1:0] em_d_i,
   output logic [gpmc_bus_pkg::EM_DATA_W-1:0] em_d_o,
   output logic                               em_d_oe_o,
   input  logic                               em_ncs4_i,
   input  logic                               em_ncs6_i,
   input  logic                               em_nwe_i,
   input  logic                               em_noe_i,
   output logic                               tx_have_space_o,
   output logic                               rx_have_data_o,
   output logic                               resp_have_data_o,
   output fifo_pkg::fifo36_word_u             tx_data_o,
   output logic                               tx_src_rdy_o,
   input  logic                               tx_dst_rdy_i,
   input  fifo_pkg::fifo36_word_u             rx_data_i,
   input  logic                               rx_src_rdy_i,
   output logic                               rx_dst_rdy_o,
   output fifo_pkg::fifo36_word_u             ctrl_data_o,
   output logic                               ctrl_src_rdy_o,
   input  logic                               ctrl_dst_rdy_i,
   input  fifo_pkg::fifo36_word_u             resp_data_i,
   input  logic                               resp_src_rdy_i,
   output logic                               resp_dst_rdy_o
);
   import gpmc_bus_pkg::*;
   import fifo_pkg::*;

   logic [ITEM_W-1:0] tx18, rx18, ctrl18, resp18;
   logic tx18_src, tx18_dst, rx18_src, rx18_dst, ctrl18_src, ctrl18_dst, resp18_src, resp18_dst;
   fifo36_word_u txw, rxw, ctrlw, respw;
   logic txw_src, txw_dst, rxw_src, rxw_dst, ctrlw_src, ctrlw_dst, respw_src, respw_dst;
   logic [EM_DATA_W-1:0] rx_d, resp_d;
   logic rx_oe, resp_oe;
   logic data_we, data_rd, ctrl_we, ctrl_rd;

   // Window strobes, control writes only below em_a_i[6]
   assign data_we = !em_ncs4_i && !em_nwe_i;
   assign data_rd = !em_ncs4_i && !em_noe_i;
   assign ctrl_we = !em_ncs6_i && !em_nwe_i && (em_a_i[EM_ADDR_W:CTRL_ADDR_W+1] == '0);
   assign ctrl_rd = !em_ncs6_i && !em_noe_i;

   //////////////////////////////////////////////////
   // Host to stream, tx on CS4 and ctrl on CS6
   gpmc_to_fifo #(.ADDR_WIDTH(DATA_ADDR_W)) u_tx_g2f (.fifo_clk_i, .rst_n_i, .we_i(data_we),
      .addr_i(em_a_i), .data_i(em_d_i), .item_o(tx18), .src_rdy_o(tx18_src),
      .dst_rdy_i(tx18_dst), .have_space_o(tx_have_space_o));
   fifo19_to_fifo36 u_tx_pack (.fifo_clk_i, .rst_n_i, .f19_data_i(tx18), .f19_src_rdy_i(tx18_src),
      .f19_dst_rdy_o(tx18_dst), .f36_data_o(txw), .f36_src_rdy_o(txw_src), .f36_dst_rdy_i(txw_dst));
   fifo_buffer #(.SIZE_LOG2(TX_FIFO_LOG2)) u_tx_buf (.fifo_clk_i, .rst_n_i, .data_i(txw),
      .src_rdy_i(txw_src), .dst_rdy_o(txw_dst), .data_o(tx_data_o), .src_rdy_o(tx_src_rdy_o),
      .dst_rdy_i(tx_dst_rdy_i));

   // Control window has no space pin
   gpmc_to_fifo #(.ADDR_WIDTH(CTRL_ADDR_W)) u_ctrl_g2f (.fifo_clk_i, .rst_n_i, .we_i(ctrl_we),
      .addr_i(em_a_i[CTRL_ADDR_W:1]), .data_i(em_d_i), .item_o(ctrl18), .src_rdy_o(ctrl18_src),
      .dst_rdy_i(ctrl18_dst), .have_space_o());
   fifo19_to_fifo36 u_ctrl_pack (.fifo_clk_i, .rst_n_i, .f19_data_i(ctrl18),
      .f19_src_rdy_i(ctrl18_src), .f19_dst_rdy_o(ctrl18_dst), .f36_data_o(ctrlw),
      .f36_src_rdy_o(ctrlw_src), .f36_dst_rdy_i(ctrlw_dst));
   fifo_buffer #(.SIZE_LOG2(CTRL_FIFO_LOG2)) u_ctrl_buf (.fifo_clk_i, .rst_n_i, .data_i(ctrlw),
      .src_rdy_i(ctrlw_src), .dst_rdy_o(ctrlw_dst), .data_o(ctrl_data_o),
      .src_rdy_o(ctrl_src_rdy_o), .dst_rdy_i(ctrl_dst_rdy_i));

   //////////////////////////////////////////////////
   // Stream to host, rx on CS4 and resp on CS6
   fifo_buffer #(.SIZE_LOG2(RX_FIFO_LOG2)) u_rx_buf (.fifo_clk_i, .rst_n_i, .data_i(rx_data_i),
      .src_rdy_i(rx_src_rdy_i), .dst_rdy_o(rx_dst_rdy_o), .data_o(rxw), .src_rdy_o(rxw_src),
      .dst_rdy_i(rxw_dst));
   fifo36_to_fifo19 u_rx_split (.fifo_clk_i, .rst_n_i, .f36_data_i(rxw), .f36_src_rdy_i(rxw_src),
      .f36_dst_rdy_o(rxw_dst), .f19_data_o(rx18), .f19_src_rdy_o(rx18_src), .f19_dst_rdy_i(rx18_dst));
   fifo_to_gpmc u_rx_f2g (.fifo_clk_i, .rst_n_i, .item_i(rx18), .src_rdy_i(rx18_src),
      .dst_rdy_o(rx18_dst), .rd_i(data_rd), .data_o(rx_d), .data_oe_o(rx_oe),
      .data_available_o(rx_have_data_o));

   fifo_buffer #(.SIZE_LOG2(CTRL_FIFO_LOG2)) u_resp_buf (.fifo_clk_i, .rst_n_i,
      .data_i(resp_data_i), .src_rdy_i(resp_src_rdy_i), .dst_rdy_o(resp_dst_rdy_o),
      .data_o(respw), .src_rdy_o(respw_src), .dst_rdy_i(respw_dst));
   fifo36_to_fifo19 u_resp_split (.fifo_clk_i, .rst_n_i, .f36_data_i(respw),
      .f36_src_rdy_i(respw_src), .f36_dst_rdy_o(respw_dst), .f19_data_o(resp18),
      .f19_src_rdy_o(resp18_src), .f19_dst_rdy_i(resp18_dst));
   fifo_to_gpmc u_resp_f2g (.fifo_clk_i, .rst_n_i, .item_i(resp18), .src_rdy_i(resp18_src),
      .dst_rdy_o(resp18_dst), .rd_i(ctrl_rd), .data_o(resp_d), .data_oe_o(resp_oe),
      .data_available_o(resp_have_data_o));

   // Read data from whichever window answered
   assign em_d_o    = rx_oe ? rx_d : (resp_oe ? resp_d : '0);
   assign em_d_oe_o = rx_oe || resp_oe;

endmodule

`default_nettype wire

//--- tb/tb_gpmc.sv
//////////////////////////////////////////////////
// Testbench for the GPMC to FIFO bridge
// Bus and stream drivers, stream monitors,
// directed tests, watchdog and the result line
//////////////////////////////////////////////////
`default_nettype none

module tb_gpmc;
   timeunit 1ns;
   timeprecision 1ps;

   import gpmc_bus_pkg::*;
   import fifo_pkg::*;

   localparam int CLK_PERIOD    = 20;
   // Transactions per test and a cycle bound for each
   localparam int TR_RESET      = 1;
   localparam int TR_TX_PACK    = 20;
   localparam int TR_TX_STALL   = 300;
   localparam int TR_RX         = 40;
   localparam int TR_CTRL       = 40;
   localparam int CYCLES_PER_TR = 25;
   localparam int WATCHDOG_CYCLES =
      (TR_RESET + TR_TX_PACK + TR_TX_STALL + TR_RX + TR_CTRL) * CYCLES_PER_TR;

   logic clk;
   logic rst_n;
   logic [EM_ADDR_W:1] em_a;
   logic [EM_DATA_W-1:0] em_d_i;
   logic [EM_DATA_W-1:0] em_d_o;
   logic em_d_oe, em_ncs4, em_ncs6, em_nwe, em_noe;
   logic tx_have_space, rx_have_data, resp_have_data;
   fifo36_word_u tx_data, rx_data, ctrl_data, resp_data;
   logic tx_src_rdy, tx_dst_rdy, rx_src_rdy, rx_dst_rdy;
   logic ctrl_src_rdy, ctrl_dst_rdy, resp_src_rdy, resp_dst_rdy;

   int value_errors = 0;
   int other_errors = 0;
   int space_budget = 0;
   bit tx_stall_en  = 1'b0;
   logic [WORD_W-1:0] exp_tx[$], got_tx[$], exp_ctrl[$], got_ctrl[$];
   logic [EM_DATA_W-1:0] frame_q[$];

   gpmc UUT (.fifo_clk_i(clk), .rst_n_i(rst_n), .em_a_i(em_a), .em_d_i(em_d_i),
      .em_d_o(em_d_o), .em_d_oe_o(em_d_oe), .em_ncs4_i(em_ncs4), .em_ncs6_i(em_ncs6),
      .em_nwe_i(em_nwe), .em_noe_i(em_noe), .tx_have_space_o(tx_have_space),
      .rx_have_data_o(rx_have_data), .resp_have_data_o(resp_have_data),
      .tx_data_o(tx_data), .tx_src_rdy_o(tx_src_rdy), .tx_dst_rdy_i(tx_dst_rdy),
      .rx_data_i(rx_data), .rx_src_rdy_i(rx_src_rdy), .rx_dst_rdy_o(rx_dst_rdy),
      .ctrl_data_o(ctrl_data), .ctrl_src_rdy_o(ctrl_src_rdy), .ctrl_dst_rdy_i(ctrl_dst_rdy),
      .resp_data_i(resp_data), .resp_src_rdy_i(resp_src_rdy), .resp_dst_rdy_o(resp_dst_rdy));

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Stream sinks with random tx stalls when enabled
   //////////////////////////////////////////////////
   always @(negedge clk) begin
      // Ready one cycle in four, so the tx path backs up to the host
      tx_dst_rdy = tx_stall_en ? ($urandom_range(0, 3) == 0) : 1'b1;
      // Word transfers at the coming rising edge
      if (tx_src_rdy && tx_dst_rdy) got_tx.push_back(tx_data);
      if (ctrl_src_rdy && ctrl_dst_rdy) got_ctrl.push_back(ctrl_data);
   end

   task automatic check_value(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
      assert (got === exp) else begin
         value_errors++;
         $display("ERROR %0t ns: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_true(input bit ok, input string what);
      assert (ok) else begin
         other_errors++;
         $display("At %0t ns: %s", $time, what);
      end
   endtask

   // Frame word from its fields with the first bus word in lo
   function automatic logic [WORD_W-1:0] make_word(input logic [1:0] occ, input logic eof,
      input logic sof, input logic [15:0] hi, input logic [15:0] lo);
      fifo36_word_u w;
      w.halves.occ = occ;
      w.halves.eof = eof;
      w.halves.sof = sof;
      w.halves.hi  = hi;
      w.halves.lo  = lo;
      return w;
   endfunction

   task automatic pack_frame(input bit ctrl_side, input logic [15:0] words[$]);
      int n;
      logic [WORD_W-1:0] w;
      n = words.size();
      for (int k = 0; k < n; k += 2) begin
         if (k + 1 < n) w = make_word(OCC_FULL, k + 2 >= n, k == 0, words[k+1], words[k]);
         // Odd tail leaves a lone low half
         else w = make_word(OCC_LOW_ONLY, 1'b1, k == 0, 16'h0, words[k]);
         if (ctrl_side) exp_ctrl.push_back(w);
         else exp_tx.push_back(w);
      end
   endtask

   task automatic make_random_frame(input int n);
      frame_q.delete();
      repeat (n) frame_q.push_back(16'($urandom));
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic bus_idle();
      em_ncs4 = 1'b1;
      em_ncs6 = 1'b1;
      em_nwe  = 1'b1;
      em_noe  = 1'b1;
   endtask

   //////////////////////////////////////////////////
   // Single-cycle host bus accesses
   //////////////////////////////////////////////////
   task automatic bus_write(input bit ctrl_side, input logic [EM_ADDR_W:1] addr,
                            input logic [15:0] data);
      em_a   = addr;
      em_d_i = data;
      em_nwe = 1'b0;
      if (ctrl_side) em_ncs6 = 1'b0;
      else em_ncs4 = 1'b0;
      @(negedge clk);
      bus_idle();
   endtask

   // Read data lands one cycle after the access
   task automatic bus_read(input bit ctrl_side, input logic [15:0] exp);
      em_a   = '0;
      em_noe = 1'b0;
      if (ctrl_side) em_ncs6 = 1'b0;
      else em_ncs4 = 1'b0;
      @(negedge clk);
      bus_idle();
      check_value("em_d_oe_o", em_d_oe, 1'b1);
      check_value("em_d_o", em_d_o, exp);
   endtask

   // Fresh budget whenever have_space is seen high
   task automatic write_data_word(input logic [EM_ADDR_W:1] addr, input logic [15:0] data);
      if (tx_have_space) space_budget = HAVE_SPACE_MIN;
      while (space_budget == 0) begin
         @(negedge clk);
         if (tx_have_space) space_budget = HAVE_SPACE_MIN;
      end
      bus_write(1'b0, addr, data);
      space_budget--;
   endtask

   // Address zero opens and the top window bit closes
   task automatic write_frame(input bit ctrl_side, input logic [15:0] words[$]);
      logic [EM_ADDR_W:1] addr;
      for (int i = 0; i < words.size(); i++) begin
         addr = i;
         if (i == words.size() - 1) addr |= ctrl_side ? 10'h010 : 10'h200;
         if (ctrl_side) bus_write(1'b1, addr, words[i]);
         else write_data_word(addr, words[i]);
      end
      pack_frame(ctrl_side, words);
   endtask

   task automatic push_stream(input bit resp_side, input logic [15:0] words[$]);
      int n;
      int waited;
      logic [WORD_W-1:0] w;
      n = words.size();
      for (int k = 0; k < n; k += 2) begin
         if (k + 1 < n) w = make_word(OCC_FULL, k + 2 >= n, k == 0, words[k+1], words[k]);
         // High half of a lone word is junk and must not be read
         else w = make_word(OCC_LOW_ONLY, 1'b1, k == 0, 16'($urandom), words[k]);
         if (resp_side) begin
            resp_data    = w;
            resp_src_rdy = 1'b1;
         end else begin
            rx_data    = w;
            rx_src_rdy = 1'b1;
         end
         waited = 0;
         while (!(resp_side ? resp_dst_rdy : rx_dst_rdy) && waited < 100) begin
            @(negedge clk);
            waited++;
         end
         check_true(waited < 100, "stream input stayed blocked, dst_rdy never rose");
         @(negedge clk);
      end
      rx_src_rdy   = 1'b0;
      resp_src_rdy = 1'b0;
   endtask

   task automatic wait_have_data(input bit resp_side);
      int waited;
      waited = 0;
      while (!(resp_side ? resp_have_data : rx_have_data) && waited < 200) begin
         @(negedge clk);
         waited++;
      end
      check_true(waited < 200, "have_data did not rise after a complete frame was pushed");
   endtask

   task automatic wait_words(input bit ctrl_side, input int n);
      int waited;
      waited = 0;
      while ((ctrl_side ? got_ctrl.size() : got_tx.size()) < n && waited < 50 * n + 100) begin
         @(negedge clk);
         waited++;
      end
      check_true(waited < 50 * n + 100, "stream output stopped before all frame words came out");
   endtask

   // hi of a lone word is not part of the frame
   task automatic compare_streams(input bit ctrl_side, input string name);
      logic [WORD_W-1:0] got_q[$];
      logic [WORD_W-1:0] exp_q[$];
      logic [WORD_W-1:0] got;
      fifo36_word_u exp;
      if (ctrl_side) begin
         got_q = got_ctrl;
         exp_q = exp_ctrl;
         check_true(got_q.size() == exp_q.size(), "ctrl word count differs");
      end else begin
         got_q = got_tx;
         exp_q = exp_tx;
         check_true(got_q.size() == exp_q.size(), "tx word count differs");
      end
      while (got_q.size() != 0 && exp_q.size() != 0) begin
         got = got_q.pop_front();
         exp = exp_q.pop_front();
         if (exp.frame.occ == OCC_LOW_ONLY) begin
            got[31:16]     = '0;
            exp.halves.hi = '0;
         end
         check_value(name, got, exp);
      end
      got_tx.delete();
      exp_tx.delete();
      got_ctrl.delete();
      exp_ctrl.delete();
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////
   task automatic test_after_reset();
      check_value("tx_src_rdy_o", tx_src_rdy, 1'b0);
      check_value("ctrl_src_rdy_o", ctrl_src_rdy, 1'b0);
      check_value("em_d_oe_o", em_d_oe, 1'b0);
      check_value("rx_have_data_o", rx_have_data, 1'b0);
      check_value("resp_have_data_o", resp_have_data, 1'b0);
      check_value("tx_have_space_o", tx_have_space, 1'b1);
      check_value("rx_dst_rdy_o", rx_dst_rdy, 1'b1);
      check_value("resp_dst_rdy_o", resp_dst_rdy, 1'b1);
   endtask

   task automatic test_tx_packing();
      int lens[4] = '{4, 7, 2, 5};
      foreach (lens[i]) begin
         make_random_frame(lens[i]);
         write_frame(1'b0, frame_q);
      end
      wait_words(1'b0, exp_tx.size());
      compare_streams(1'b0, "tx_data_o");
   endtask

   task automatic test_tx_stall();
      tx_stall_en = 1'b1;
      repeat (40) begin
         make_random_frame($urandom_range(2, 12));
         write_frame(1'b0, frame_q);
      end
      wait_words(1'b0, exp_tx.size());
      compare_streams(1'b0, "tx_data_o");
      tx_stall_en = 1'b0;
   endtask

   task automatic test_rx_read();
      int lens[3] = '{5, 8, 3};
      logic [15:0] expect_q[$];
      foreach (lens[i]) begin
         make_random_frame(lens[i]);
         expect_q = {expect_q, frame_q};
         push_stream(1'b0, frame_q);
      end
      // Each frame is read once have_data is high
      foreach (lens[i]) begin
         wait_have_data(1'b0);
         repeat (lens[i]) bus_read(1'b0, expect_q.pop_front());
      end
      check_value("rx_have_data_o", rx_have_data, 1'b0);
      bus_read(1'b0, 16'h0);
   endtask

   task automatic test_ctrl();
      make_random_frame(6);
      // Strays above em_a_i[5] must be dropped
      for (int i = 0; i < 6; i++) begin
         bus_write(1'b1, 10'h020 << (i % 5), 16'hdead);
         bus_write(1'b1, (i == 5) ? 10'h010 | i : i, frame_q[i]);
      end
      pack_frame(1'b1, frame_q);
      make_random_frame(5);
      write_frame(1'b1, frame_q);
      wait_words(1'b1, exp_ctrl.size());
      idle(20);
      compare_streams(1'b1, "ctrl_data_o");
      // Response direction through CS6
      make_random_frame(5);
      push_stream(1'b1, frame_q);
      wait_have_data(1'b1);
      foreach (frame_q[i]) bus_read(1'b1, frame_q[i]);
      check_value("resp_have_data_o", resp_have_data, 1'b0);
   endtask

   initial begin
      void'($urandom(56));
      rst_n        = 1'b0;
      em_a         = '0;
      em_d_i       = '0;
      bus_idle();
      rx_data      = '0;
      rx_src_rdy   = 1'b0;
      resp_data    = '0;
      resp_src_rdy = 1'b0;
      tx_dst_rdy   = 1'b1;
      ctrl_dst_rdy = 1'b1;
      repeat (3) @(negedge clk);
      rst_n = 1'b1;
      test_after_reset();
      test_tx_packing();
      test_tx_stall();
      test_rx_read();
      test_ctrl();
      idle(2);
      $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
      if (value_errors + other_errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // Watchdog bound taken from the test lengths
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
rtl/gpmc_bus_pkg.sv
rtl/fifo_pkg.sv
rtl/fifo_buffer.sv
rtl/gpmc_to_fifo.sv
rtl/fifo_to_gpmc.sv
rtl/fifo19_to_fifo36.sv
rtl/fifo36_to_fifo19.sv
rtl/gpmc.sv
tb/tb_gpmc.sv
